//--- logic/decode_pkg.sv
package decode_pkg;

	// data, instruction and pc words
	typedef logic [31:0] word_t;

	// register number, r0 to r15
	typedef logic [3:0] reg_idx_t;

	// instruction class handed to the next stage
	typedef logic [2:0] insn_class_t;

	// zero so that the reset value of op_class reads as "nothing decoded"
	localparam insn_class_t CLASS_OTHER  = 3'd0;
	localparam insn_class_t CLASS_ALU    = 3'd1;
	localparam insn_class_t CLASS_MULT   = 3'd2;
	localparam insn_class_t CLASS_LDRSTR = 3'd3;
	localparam insn_class_t CLASS_LDMSTM = 3'd4;
	localparam insn_class_t CLASS_BRANCH = 3'd5;
	localparam insn_class_t CLASS_BX     = 3'd6;

	// shift kind, instruction bits 6:5
	typedef logic [1:0] shift_kind_t;

	localparam shift_kind_t SHIFT_LSL = 2'b00;
	localparam shift_kind_t SHIFT_LSR = 2'b01;
	localparam shift_kind_t SHIFT_ASR = 2'b10;
	localparam shift_kind_t SHIFT_ROR = 2'b11;

	localparam reg_idx_t PC_REG = 4'd15;

	// r15 reads back the fetch pc minus the pipeline offset
	localparam word_t PC_OFFSET_STD = 32'd8;
	// one more word when the shift amount comes from a register
	localparam word_t PC_OFFSET_REGSHIFT = 32'd12;

	// decode_ctrl handshake states
	typedef enum logic [1:0] {
		IDLE,
		FETCH,
		OFFER,
		RELEASE
	} ctrl_state_t;

endpackage

//--- logic/regfile_rd_if.sv
`timescale 1ns/1ps

interface regfile_rd_if import decode_pkg::*; ();

	reg_idx_t addr0;
	reg_idx_t addr1;
	reg_idx_t addr2;
	word_t data0;
	word_t data1;
	word_t data2;

	// decode_ctrl picks the registers
	modport ctrl (output addr0, addr1, addr2);

	// register file answers
	modport rf (input addr0, addr1, addr2, output data0, data1, data2);

	// operand_select consumes the read data
	modport data (input data0, data1, data2);

endinterface

//--- logic/reg_file.sv
`timescale 1ns/1ps

module reg_file import decode_pkg::*; (
	input logic clk,
	input logic arst_n,
	input logic wr_en,
	input reg_idx_t wr_addr,
	input word_t wr_data,
	input word_t pc_q,
	input insn_class_t insn_class,
	input word_t insn_q,
	regfile_rd_if.rf rd
);

	// r0..r14 only, r15 is never stored
	word_t regs [0:14];
	word_t pc_read;
	logic reg_shift;

	// data processing with a register-specified shift sees pc - 12
	assign reg_shift = (insn_class == CLASS_ALU) && !insn_q[25] && insn_q[4];
	assign pc_read = pc_q - (reg_shift ? PC_OFFSET_REGSHIFT : PC_OFFSET_STD);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < 15; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en && wr_addr != PC_REG) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// three combinational read ports
	assign rd.data0 = (rd.addr0 == PC_REG) ? pc_read : regs[rd.addr0];
	assign rd.data1 = (rd.addr1 == PC_REG) ? pc_read : regs[rd.addr1];
	assign rd.data2 = (rd.addr2 == PC_REG) ? pc_read : regs[rd.addr2];

	a_wr_addr_known: assert property (
		@(posedge clk) disable iff (!arst_n)
		wr_en |-> !$isunknown(wr_addr)
	) else $error("reg_file: write with unknown address %b", wr_addr);

endmodule

//--- logic/barrel_shifter.sv
`timescale 1ns/1ps

module barrel_shifter import decode_pkg::*; (
	input word_t operand,
	input word_t insn_q,
	input word_t reg_amt,
	input logic carry_in,
	output word_t result,
	output logic carry_out
);

	shift_kind_t kind;
	logic [4:0] imm_amt;
	logic [7:0] reg_byte;
	logic [5:0] amt;
	logic over;
	logic rrx;
	logic is_lsl;
	logic is_rot;
	logic is_arith;
	logic fill_bit;
	word_t net_in;
	word_t net_out;
	logic net_carry;
	// {data, carry} after each stage
	logic [32:0] stg [0:5];

	function automatic word_t reverse_word(input word_t w);
		word_t r;
		for (int i = 0; i < 32; i++) begin
			r[i] = w[31 - i];
		end
		return r;
	endfunction

	assign kind = insn_q[6:5];
	assign imm_amt = insn_q[11:7];
	assign reg_byte = reg_amt[7:0];

	assign is_lsl = (kind == SHIFT_LSL);
	assign is_rot = (kind == SHIFT_ROR);
	assign is_arith = (kind == SHIFT_ASR);
	assign fill_bit = is_arith & operand[31];

	// immediate ROR #0 encodes RRX
	assign rrx = !insn_q[4] && is_rot && (imm_amt == 5'd0);

	// effective amount, clamped to 0..32
	always_comb begin
		over = 1'b0;
		if (insn_q[4]) begin
			if (is_rot) begin
				// nonzero multiple of 32 rotates fully round and only updates carry
				if (reg_byte != 8'd0 && reg_byte[4:0] == 5'd0)
					amt = 6'd32;
				else
					amt = {1'b0, reg_byte[4:0]};
			end else if (reg_byte >= 8'd32) begin
				amt = 6'd32;
				over = (reg_byte != 8'd32);
			end else begin
				amt = {1'b0, reg_byte[4:0]};
			end
		end else if (imm_amt == 5'd0 && (kind == SHIFT_LSR || kind == SHIFT_ASR)) begin
			amt = 6'd32;
		end else begin
			amt = {1'b0, imm_amt};
		end
	end

	// left shifts run through the right-shift network bit reversed
	assign net_in = is_lsl ? reverse_word(operand) : operand;

	assign stg[0] = amt[5] ? {is_rot ? net_in : {32{fill_bit}}, net_in[31]}
	                       : {net_in, carry_in};

	for (genvar k = 0; k < 5; k++) begin : g_stage
		localparam int N = 1 << k;
		assign stg[k + 1] = amt[k] ?
			{is_rot ? stg[k][N:1] : {N{fill_bit}}, stg[k][32:N + 1], stg[k][N]} : stg[k];
	end

	assign net_out = stg[5][32:1];
	assign net_carry = stg[5][0];

	always_comb begin
		if (rrx) begin
			result = {carry_in, operand[31:1]};
			carry_out = operand[0];
		end else begin
			result = is_lsl ? reverse_word(net_out) : net_out;
			// logical shifts past 32 push out zeros, carry included
			carry_out = (over && !is_arith) ? 1'b0 : net_carry;
		end
	end

	always_comb begin
		if (insn_q[4] && reg_byte < 8'd32 &&
		    !$isunknown({operand, insn_q, reg_byte, carry_in})) begin
			a_known_result: assert (!$isunknown(result))
				else $error("barrel_shifter: unknown result for amount %0d", reg_byte);
		end
	end

endmodule

//--- logic/operand_select.sv
`timescale 1ns/1ps

module operand_select import decode_pkg::*; (
	input logic clk,
	input logic arst_n,
	input logic capture,
	input word_t insn_q,
	input logic carry_q,
	input insn_class_t insn_class,
	input word_t shift_result,
	input logic shift_carry,
	output word_t shift_operand,
	output word_t shift_reg_amt,
	regfile_rd_if.data rd,
	output word_t op0,
	output word_t op1,
	output word_t op2,
	output logic carry,
	output insn_class_t op_class
);

	word_t imm_rot;
	word_t op0_d;
	word_t op1_d;
	word_t op2_d;
	logic carry_d;

	// 8-bit immediate rotated right by twice the 4-bit field
	function automatic word_t rotate_imm(input logic [7:0] imm, input logic [3:0] rot);
		logic [63:0] dbl;
		dbl = {24'd0, imm, 24'd0, imm};
		return dbl[{rot, 1'b0} +: 32];
	endfunction

	assign imm_rot = rotate_imm(insn_q[7:0], insn_q[11:8]);

	// Rm goes through the shifter, Rs supplies a register amount
	assign shift_operand = rd.data1;
	assign shift_reg_amt = rd.data2;

	always_comb begin
		op0_d = '0;
		op1_d = '0;
		op2_d = '0;
		carry_d = carry_q;
		case (insn_class)
			CLASS_ALU: begin
				op0_d = rd.data0;
				if (insn_q[25]) begin
					op1_d = imm_rot;
				end else begin
					op1_d = shift_result;
					carry_d = shift_carry;
				end
			end
			CLASS_MULT: begin
				op0_d = rd.data0;
				op1_d = rd.data1;
				op2_d = rd.data2;
			end
			CLASS_LDRSTR: begin
				op0_d = rd.data0;
				// for transfers the I bit set means a register offset
				if (insn_q[25]) begin
					op1_d = shift_result;
					carry_d = shift_carry;
				end else begin
					op1_d = {20'd0, insn_q[11:0]};
				end
			end
			CLASS_LDMSTM: begin
				op0_d = rd.data0;
				op1_d = {16'd0, insn_q[15:0]};
			end
			CLASS_BRANCH: begin
				// word offset, sign extended to a byte offset
				op0_d = {{6{insn_q[23]}}, insn_q[23:0], 2'b00};
			end
			CLASS_BX: begin
				op0_d = rd.data0;
			end
			default: begin
				carry_d = 1'b0;
			end
		endcase
	end

	// outputs hold until the next capture
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			op0 <= '0;
			op1 <= '0;
			op2 <= '0;
			carry <= 1'b0;
			op_class <= CLASS_OTHER;
		end else if (capture) begin
			op0 <= op0_d;
			op1 <= op1_d;
			op2 <= op2_d;
			carry <= carry_d;
			op_class <= insn_class;
		end
	end

endmodule

//--- logic/decode_ctrl.sv
`timescale 1ns/1ps

module decode_ctrl import decode_pkg::*; (
	input logic clk,
	input logic arst_n,
	input logic insn_req,
	input word_t insn,
	input word_t pc,
	input logic cpsr_c,
	input logic op_ack,
	output logic insn_ack,
	output logic op_req,
	output logic capture,
	output word_t insn_q,
	output word_t pc_q,
	output logic carry_q,
	output insn_class_t insn_class,
	regfile_rd_if.ctrl rd
);

	ctrl_state_t state;
	logic accept;

	// multiply is a corner of the data processing space, so it goes first
	function automatic insn_class_t classify(input word_t w);
		if (w[27:22] == 6'b000000 && w[7:4] == 4'b1001)
			return CLASS_MULT;
		if (w[27:4] == 24'h12fff1)
			return CLASS_BX;
		if (w[27:26] == 2'b00) begin
			// halfword transfers, swap and long multiply
			if (!w[25] && w[7] && w[4])
				return CLASS_OTHER;
			// psr transfers, test ops without the S bit
			if (w[24:23] == 2'b10 && !w[20])
				return CLASS_OTHER;
			return CLASS_ALU;
		end
		if (w[27:26] == 2'b01)
			return (w[25] && w[4]) ? CLASS_OTHER : CLASS_LDRSTR;
		if (w[27:25] == 3'b100)
			return CLASS_LDMSTM;
		if (w[27:25] == 3'b101)
			return CLASS_BRANCH;
		return CLASS_OTHER;
	endfunction

	// a new request is taken only once the previous ack has dropped
	assign accept = (state == IDLE) && insn_req && !insn_ack;
	assign capture = (state == FETCH);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= IDLE;
			insn_ack <= 1'b0;
			op_req <= 1'b0;
			insn_class <= CLASS_OTHER;
		end else begin
			if (insn_ack && !insn_req)
				insn_ack <= 1'b0;
			case (state)
				IDLE: begin
					if (accept) begin
						insn_ack <= 1'b1;
						insn_class <= classify(insn);
						state <= FETCH;
					end
				end
				FETCH: begin
					op_req <= 1'b1;
					state <= OFFER;
				end
				OFFER: begin
					if (op_ack) begin
						op_req <= 1'b0;
						state <= RELEASE;
					end
				end
				RELEASE: begin
					if (!op_ack)
						state <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			insn_q <= insn;
			pc_q <= pc;
			carry_q <= cpsr_c;
		end
	end

	// unused ports read r0
	always_comb begin
		rd.addr0 = '0;
		rd.addr1 = '0;
		rd.addr2 = '0;
		case (insn_class)
			CLASS_ALU: begin
				rd.addr0 = insn_q[19:16];
				rd.addr1 = insn_q[3:0];
				rd.addr2 = insn_q[11:8];
			end
			CLASS_MULT: begin
				rd.addr0 = insn_q[15:12];
				rd.addr1 = insn_q[3:0];
				rd.addr2 = insn_q[11:8];
			end
			CLASS_LDRSTR: begin
				rd.addr0 = insn_q[19:16];
				rd.addr1 = insn_q[3:0];
			end
			CLASS_LDMSTM: rd.addr0 = insn_q[19:16];
			CLASS_BX: rd.addr0 = insn_q[3:0];
			default: ;
		endcase
	end

	a_op_req_held: assert property (
		@(posedge clk) disable iff (!arst_n)
		op_req && !op_ack |=> op_req
	) else $error("decode_ctrl: op_req dropped without op_ack in state %s", state.name());

endmodule

//--- logic/decode_unit.sv
`timescale 1ns/1ps

module decode_unit import decode_pkg::*; (
	input logic clk,
	input logic arst_n,
	input logic insn_req,
	input word_t insn,
	input word_t pc,
	input logic cpsr_c,
	input logic op_ack,
	input logic wr_en,
	input reg_idx_t wr_addr,
	input word_t wr_data,
	output logic insn_ack,
	output logic op_req,
	output word_t op0,
	output word_t op1,
	output word_t op2,
	output logic carry,
	output insn_class_t op_class
);

	logic capture;
	word_t insn_q;
	word_t pc_q;
	logic carry_q;
	insn_class_t insn_class;
	word_t shift_operand;
	word_t shift_reg_amt;
	word_t shift_result;
	logic shift_carry;

	regfile_rd_if rd_bus ();

	decode_ctrl u_ctrl (
		.clk        (clk),
		.arst_n     (arst_n),
		.insn_req   (insn_req),
		.insn       (insn),
		.pc         (pc),
		.cpsr_c     (cpsr_c),
		.op_ack     (op_ack),
		.insn_ack   (insn_ack),
		.op_req     (op_req),
		.capture    (capture),
		.insn_q     (insn_q),
		.pc_q       (pc_q),
		.carry_q    (carry_q),
		.insn_class (insn_class),
		.rd         (rd_bus.ctrl)
	);

	reg_file u_rf (
		.clk        (clk),
		.arst_n     (arst_n),
		.wr_en      (wr_en),
		.wr_addr    (wr_addr),
		.wr_data    (wr_data),
		.pc_q       (pc_q),
		.insn_class (insn_class),
		.insn_q     (insn_q),
		.rd         (rd_bus.rf)
	);

	// operand 2 shifter, fed from Rm and Rs
	barrel_shifter u_shift (
		.operand   (shift_operand),
		.insn_q    (insn_q),
		.reg_amt   (shift_reg_amt),
		.carry_in  (carry_q),
		.result    (shift_result),
		.carry_out (shift_carry)
	);

	operand_select u_opsel (
		.clk           (clk),
		.arst_n        (arst_n),
		.capture       (capture),
		.insn_q        (insn_q),
		.carry_q       (carry_q),
		.insn_class    (insn_class),
		.shift_result  (shift_result),
		.shift_carry   (shift_carry),
		.shift_operand (shift_operand),
		.shift_reg_amt (shift_reg_amt),
		.rd            (rd_bus.data),
		.op0           (op0),
		.op1           (op1),
		.op2           (op2),
		.carry         (carry),
		.op_class      (op_class)
	);

endmodule

//--- verif/tb_decode_model.svh
`ifndef TB_DECODE_MODEL_SVH
`define TB_DECODE_MODEL_SVH

// operand 2 shift, returns {carry, result}
function automatic logic [32:0] shift_ref(input word_t val, input logic [1:0] kind,
		input logic by_reg, input logic [7:0] amt, input logic cin);
	word_t r;
	logic c;
	logic [63:0] wide;
	int n;
	n = amt;
	r = val;
	c = cin;
	if (!by_reg && amt == 8'd0) begin
		// immediate zero encodes LSL #0, LSR #32, ASR #32 and RRX
		case (kind)
			2'd1: begin
				r = '0;
				c = val[31];
			end
			2'd2: begin
				r = {32{val[31]}};
				c = val[31];
			end
			2'd3: begin
				r = {cin, val[31:1]};
				c = val[0];
			end
			default: ;
		endcase
	end else if (amt != 8'd0) begin
		case (kind)
			2'd0: begin
				if (n < 32) begin
					wide = {32'd0, val} << n;
					r = wide[31:0];
					c = wide[32];
				end else begin
					r = '0;
					c = (n == 32) ? val[0] : 1'b0;
				end
			end
			2'd1: begin
				r = (n < 32) ? (val >> n) : '0;
				c = (n < 32) ? val[n - 1] : ((n == 32) ? val[31] : 1'b0);
			end
			2'd2: begin
				r = (n < 32) ? word_t'($signed(val) >>> n) : {32{val[31]}};
				c = (n < 32) ? val[n - 1] : val[31];
			end
			default: begin
				n = amt[4:0];
				if (n == 0) begin
					c = val[31];
				end else begin
					r = (val >> n) | (val << (32 - n));
					c = r[31];
				end
			end
		endcase
	end
	return {c, r};
endfunction

function automatic word_t rotate_ref(input logic [7:0] imm, input logic [3:0] rot);
	word_t v;
	int n;
	v = {24'd0, imm};
	n = 2 * rot;
	return (n == 0) ? v : ((v >> n) | (v << (32 - n)));
endfunction

function automatic word_t pc_ref(input word_t fetch_pc, input logic reg_shift);
	return fetch_pc - (reg_shift ? 32'd12 : 32'd8);
endfunction

function automatic word_t read_ref(input reg_idx_t idx, input word_t fetch_pc,
		input logic reg_shift);
	return (idx == 4'd15) ? pc_ref(fetch_pc, reg_shift) : regs_m[idx];
endfunction

function automatic void expect_operands(input word_t w, input word_t fpc, input logic cin,
		input insn_class_t cls);
	logic rs;
	word_t rs_val;
	logic [7:0] amt;
	logic [32:0] sh;
	rs = (cls == CLASS_ALU) && !w[25] && w[4];
	// register amounts use only the low byte of Rs
	rs_val = read_ref(w[11:8], fpc, rs);
	amt = w[4] ? rs_val[7:0] : {3'd0, w[11:7]};
	sh = shift_ref(read_ref(w[3:0], fpc, rs), w[6:5], w[4], amt, cin);
	exp_op0 = '0;
	exp_op1 = '0;
	exp_op2 = '0;
	exp_carry = cin;
	exp_class = cls;
	case (cls)
		CLASS_ALU: begin
			exp_op0 = read_ref(w[19:16], fpc, rs);
			exp_op1 = w[25] ? rotate_ref(w[7:0], w[11:8]) : sh[31:0];
			exp_carry = w[25] ? cin : sh[32];
		end
		CLASS_MULT: begin
			exp_op0 = read_ref(w[15:12], fpc, 1'b0);
			exp_op1 = read_ref(w[3:0], fpc, 1'b0);
			exp_op2 = read_ref(w[11:8], fpc, 1'b0);
		end
		CLASS_LDRSTR: begin
			exp_op0 = read_ref(w[19:16], fpc, 1'b0);
			exp_op1 = w[25] ? sh[31:0] : {20'd0, w[11:0]};
			exp_carry = w[25] ? sh[32] : cin;
		end
		CLASS_LDMSTM: begin
			exp_op0 = read_ref(w[19:16], fpc, 1'b0);
			exp_op1 = {16'd0, w[15:0]};
		end
		CLASS_BRANCH: exp_op0 = word_t'($signed(w[23:0])) << 2;
		CLASS_BX: exp_op0 = read_ref(w[3:0], fpc, 1'b0);
		default: exp_carry = 1'b0;
	endcase
endfunction

`endif

//--- verif/tb_decode_unit.sv
`timescale 1ns/1ps

module tb_decode_unit import decode_pkg::*; ;

	localparam int NUM_INSN = 80;
	localparam int CYCLE_LIMIT = 40 * NUM_INSN;

	logic clk = 1'b0;
	logic arst_n;
	logic insn_req, cpsr_c, op_ack, wr_en;
	word_t insn, pc, wr_data;
	reg_idx_t wr_addr;
	logic insn_ack, op_req, carry;
	word_t op0, op1, op2;
	insn_class_t op_class;

	word_t regs_m [0:15];
	word_t exp_op0, exp_op1, exp_op2;
	logic exp_carry;
	insn_class_t exp_class;
	string test_name = "reset";
	int cycles = 0;
	int issued = 0;

	`include "tb_decode_model.svh"

	decode_unit uut (.*);

	always #50 clk = ~clk;

	task automatic stop_on_error(input string what);
		$display("%s", what);
		$display("*** FAILED ***");
		$fatal(1);
	endtask

	task automatic mismatch(input string field, input word_t expv, input word_t actv);
		stop_on_error($sformatf("MISMATCH %s %s: expected %h, actual %h",
			test_name, field, expv, actv));
	endtask

	always @(posedge clk) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT)
			stop_on_error($sformatf("timeout after %0d cycles, %0d issued", cycles, issued));
	end

	// operands checked when the offer opens
	a_op0: assert property (@(posedge clk) disable iff (!arst_n) $rose(op_req) |-> op0 == exp_op0)
		else mismatch("op0", exp_op0, op0);
	a_op1: assert property (@(posedge clk) disable iff (!arst_n) $rose(op_req) |-> op1 == exp_op1)
		else mismatch("op1", exp_op1, op1);
	a_op2: assert property (@(posedge clk) disable iff (!arst_n) $rose(op_req) |-> op2 == exp_op2)
		else mismatch("op2", exp_op2, op2);
	a_carry: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(op_req) |-> carry == exp_carry)
		else mismatch("carry", {31'd0, exp_carry}, {31'd0, carry});
	a_class: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(op_req) |-> op_class == exp_class)
		else mismatch("class", {29'd0, exp_class}, {29'd0, op_class});

	// two cycles from the sampling edge to op_req
	a_req_timing: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(insn_ack) |=> $rose(op_req))
		else stop_on_error($sformatf("%s: op_req not raised one cycle after insn_ack", test_name));
	a_ack_fall: assert property (@(posedge clk) disable iff (!arst_n)
		$fell(insn_ack) |-> !$past(insn_req))
		else stop_on_error($sformatf("%s: insn_ack fell while insn_req was high", test_name));
	a_no_accept_busy: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(insn_ack) |-> !$past(op_req) && !$past(op_ack))
		else stop_on_error($sformatf("%s: request acknowledged during an offer", test_name));
	a_hold: assert property (@(posedge clk) disable iff (!arst_n)
		op_req && !op_ack |=> op_req && $stable({op0, op1, op2, carry, op_class}))
		else stop_on_error($sformatf("%s: outputs moved under back-pressure", test_name));

	function automatic word_t enc_alu_imm(input logic [3:0] opc, input reg_idx_t rn,
			input logic [3:0] rot, input logic [7:0] imm);
		return {4'he, 3'b001, opc, 1'b1, rn, 4'd0, rot, imm};
	endfunction

	function automatic word_t enc_alu_sh(input logic [3:0] opc, input reg_idx_t rn,
			input reg_idx_t rm, input logic [4:0] amt, input logic [1:0] kind);
		return {4'he, 3'b000, opc, 1'b1, rn, 4'd0, amt, kind, 1'b0, rm};
	endfunction

	function automatic word_t enc_alu_rs(input logic [3:0] opc, input reg_idx_t rn,
			input reg_idx_t rm, input reg_idx_t rs, input logic [1:0] kind);
		return {4'he, 3'b000, opc, 1'b1, rn, 4'd0, rs, 1'b0, kind, 1'b1, rm};
	endfunction

	task automatic write_reg(input reg_idx_t idx, input word_t val);
		wr_en = 1'b1;
		wr_addr = idx;
		wr_data = val;
		@(posedge clk);
		#5 wr_en = 1'b0;
		if (idx != 4'd15)
			regs_m[idx] = val;
	endtask

	// one full input exchange, new pc and carry each time
	task automatic issue(input string name, input word_t w, input insn_class_t cls);
		word_t pc_v;
		logic c_v;
		pc_v = $urandom & 32'hffff_fffc;
		c_v = 1'($urandom);
		test_name = name;
		expect_operands(w, pc_v, c_v, cls);
		insn = w;
		pc = pc_v;
		cpsr_c = c_v;
		insn_req = 1'b1;
		do @(posedge clk); while (!insn_ack);
		#5 insn_req = 1'b0;
		do @(posedge clk); while (insn_ack);
		#5;
		issued++;
	endtask

	// consumer with random back-pressure
	initial begin
		int wait_cycles;
		op_ack = 1'b0;
		forever begin
			do @(posedge clk); while (!op_req);
			wait_cycles = $urandom % 7;
			repeat (wait_cycles) @(posedge clk);
			#5 op_ack = 1'b1;
			do @(posedge clk); while (op_req);
			#5 op_ack = 1'b0;
		end
	end

	initial begin
		string kn [0:3];
		logic [4:0] imm_amts [0:2];
		reg_idx_t rs_list [0:4];
		int sel;
		kn = '{"lsl", "lsr", "asr", "ror"};
		imm_amts = '{5'd0, 5'd1, 5'd31};
		rs_list = '{4'd9, 4'd10, 4'd11, 4'd12, 4'd13};
		void'($urandom(32'h5746da6c));
		arst_n = 1'b0;
		insn_req = 1'b0;
		insn = '0;
		pc = '0;
		cpsr_c = 1'b0;
		wr_en = 1'b0;
		wr_addr = '0;
		wr_data = '0;
		for (int i = 0; i < 16; i++)
			regs_m[i] = '0;
		repeat (10) @(posedge clk);
		a_reset: assert (!insn_ack && !op_req && op0 == '0 && op1 == '0 && op2 == '0)
			else stop_on_error("handshake or operands not cleared by reset");
		#5 arst_n = 1'b1;

		for (int i = 0; i < 16; i++)
			write_reg(reg_idx_t'(i), $urandom);
		// shift amounts 64, 0, 32, 40 and 5
		write_reg(4'd9, 32'hdead_0040);
		write_reg(4'd10, 32'h0000_0100);
		write_reg(4'd11, 32'h0000_0020);
		write_reg(4'd12, 32'h0000_0028);
		write_reg(4'd13, 32'h8000_0005);
		write_reg(4'd3, 32'h8000_0001);

		issue("alu imm rot0", enc_alu_imm(4'd4, 4'd1, 4'd0, 8'h5a), CLASS_ALU);
		issue("alu imm rot4", enc_alu_imm(4'd0, 4'd2, 4'd4, 8'hc3), CLASS_ALU);
		issue("alu imm rot15", enc_alu_imm(4'd13, 4'd0, 4'd15, 8'hff), CLASS_ALU);
		for (int k = 0; k < 4; k++) begin
			for (int a = 0; a < 3; a++)
				issue($sformatf("%s imm %0d", kn[k], imm_amts[a]),
					enc_alu_sh(4'd4, 4'd5, 4'd3, imm_amts[a], 2'(k)), CLASS_ALU);
			for (int r = 0; r < 5; r++)
				issue($sformatf("%s by r%0d", kn[k], rs_list[r]),
					enc_alu_rs(4'd2, 4'd6, 4'd3, rs_list[r], 2'(k)), CLASS_ALU);
		end
		issue("r15 std", enc_alu_imm(4'd4, 4'd15, 4'd0, 8'd1), CLASS_ALU);
		issue("r15 regshift", enc_alu_rs(4'd4, 4'd15, 4'd15, 4'd13, 2'd0), CLASS_ALU);
		issue("mult", 32'he000_0090 | (32'd7 << 12) | (32'd8 << 8) | 32'd3, CLASS_MULT);
		issue("ldr imm", 32'he590_0000 | (32'd4 << 16) | 32'habc, CLASS_LDRSTR);
		issue("ldr reg", 32'he790_0000 | (32'd15 << 16) | (32'd3 << 7) | (32'd2 << 5) | 32'd3,
			CLASS_LDRSTR);
		issue("ldm", 32'he890_0000 | (32'd11 << 16) | 32'h80f1, CLASS_LDMSTM);
		issue("branch fwd", 32'hea00_0123, CLASS_BRANCH);
		issue("branch back", 32'heaff_fffd, CLASS_BRANCH);
		issue("bx", 32'he12f_ff10 | 32'd14, CLASS_BX);
		issue("swi", 32'hef00_0011, CLASS_OTHER);
		issue("ldrh", 32'he1d0_00b0, CLASS_OTHER);

		while (issued < NUM_INSN) begin
			sel = $urandom % 3;
			case (sel)
				0: issue("random imm", enc_alu_imm(4'($urandom), 4'($urandom), 4'($urandom),
					8'($urandom)), CLASS_ALU);
				1: issue("random shift", enc_alu_sh(4'($urandom), 4'($urandom), 4'($urandom),
					5'($urandom), 2'($urandom)), CLASS_ALU);
				default: issue("random regshift", enc_alu_rs(4'($urandom), 4'($urandom),
					4'($urandom), 4'($urandom), 2'($urandom)), CLASS_ALU);
			endcase
		end

		// let the last offer complete
		while (op_req || op_ack)
			@(posedge clk);
		repeat (2) @(posedge clk);
		$display("*** PASSED ***");
		$finish;
	end

endmodule

//--- compile.f
+incdir+verif
logic/decode_pkg.sv
logic/regfile_rd_if.sv
logic/reg_file.sv
logic/barrel_shifter.sv
logic/operand_select.sv
logic/decode_ctrl.sv
logic/decode_unit.sv
verif/tb_decode_unit.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert --timing -Wno-fatal
TOP       ?= tb_decode_unit
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove build output and log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q '\*\*\* PASSED \*\*\*' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
